// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

	// datapath and register file geometry
	localparam int WORD_W    = 16;
	localparam int REG_IDX_W = 4;

	// one word is data, byte address and instruction alike
	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// branch offset field, counted in half-words
	typedef logic [8:0] imm9_t;

	// immediate byte of llb / lhb
	typedef logic [7:0] byte_t;

	// top nibble of the instruction
	typedef enum logic [3:0] {
		OP_ADD    = 4'h0,
		OP_SUB    = 4'h1,
		OP_XOR    = 4'h2,
		OP_AND    = 4'h3,
		OP_OR     = 4'h4,
		OP_SLL    = 4'h5,
		OP_SRL    = 4'h6,
		OP_SRA    = 4'h7,
		OP_LW     = 4'h8,
		OP_SW     = 4'h9,
		OP_LLB    = 4'hA,
		OP_LHB    = 4'hB,
		OP_BRANCH = 4'hC,
		// unused slot, executes as a no-op
		OP_NOP    = 4'hD,
		OP_PCS    = 4'hE,
		OP_HLT    = 4'hF
	} opcode_t;

	// branch condition, bits 11..9 of a branch
	typedef enum logic [2:0] {
		COND_NE     = 3'd0,
		COND_EQ     = 3'd1,
		COND_GT     = 3'd2,
		COND_LT     = 3'd3,
		COND_GE     = 3'd4,
		COND_LE     = 3'd5,
		COND_OV     = 3'd6,
		COND_ALWAYS = 3'd7
	} cond_t;

	// zero, overflow, negative
	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

endpackage

// File: cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;
	import cpu_isa_pkg::*;

	// alu operation, same encoding as opcodes 0..7
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_XOR = 3'd2,
		ALU_AND = 3'd3,
		ALU_OR  = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6,
		ALU_SRA = 3'd7
	} alu_op_t;

	// source of the register write-back value
	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_MEM  = 2'd1,
		WB_BYTE = 2'd2,
		WB_PCS  = 2'd3
	} wb_sel_t;

	// everything decode hands to the rest of the core
	typedef struct packed {
		logic    reg_write;
		logic    mem_write;
		logic    use_imm;
		alu_op_t alu_op;
		wb_sel_t wb_sel;
		// lhb when set, llb otherwise
		logic    high_byte;
		logic    branch;
		cond_t   cond;
		logic    halt;
		logic    flag_z_en;
		logic    flag_vn_en;
		// already sign extended and scaled where needed
		word_t   imm;
		byte_t   byte_val;
	} ctrl_t;

endpackage

// File: cpu_fetch.sv
`timescale 1ns/1ps

module cpu_fetch import cpu_isa_pkg::*; import cpu_ctrl_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input  logic   clk,
	input  logic   rst_n,
	input  ctrl_t  ctrl,
	input  flags_t flags,
	output word_t  pc
);

	word_t pc_plus2;
	word_t target;
	word_t pc_next;
	logic  cond_met;

	// sequential successor, also the base of a branch
	assign pc_plus2 = pc + 16'd2;

	// decode already turned imm9 into a signed byte offset
	assign target = pc_plus2 + ctrl.imm;

	// condition against the flag register
	always_comb begin
		unique case (ctrl.cond)
			COND_NE:     cond_met = !flags.z;
			COND_EQ:     cond_met = flags.z;
			// strictly greater: neither zero nor negative
			COND_GT:     cond_met = !flags.z && !flags.n;
			COND_LT:     cond_met = flags.n;
			COND_GE:     cond_met = flags.z || !flags.n;
			COND_LE:     cond_met = flags.n || flags.z;
			COND_OV:     cond_met = flags.v;
			COND_ALWAYS: cond_met = 1'b1;
		endcase
	end

	// next pc
	always_comb begin
		if (ctrl.halt) begin
			// hold so the hlt word is fetched again
			pc_next = pc;
		end else if (ctrl.branch && cond_met) begin
			pc_next = target;
		end else begin
			pc_next = pc_plus2;
		end
	end

	// program counter
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

// File: cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode import cpu_isa_pkg::*; import cpu_ctrl_pkg::*; (
	input  word_t    instr,
	output ctrl_t    ctrl,
	output reg_idx_t rs,
	output reg_idx_t rt,
	output reg_idx_t rd
);

	opcode_t  opcode;
	reg_idx_t f_rd;
	reg_idx_t f_rs;
	reg_idx_t f_rt;
	imm9_t    imm9;
	word_t    imm4_sext;

	// raw instruction fields
	assign opcode = opcode_t'(instr[15:12]);
	assign f_rd   = instr[11:8];
	assign f_rs   = instr[7:4];
	assign f_rt   = instr[3:0];
	assign imm9   = instr[8:0];

	// imm4 sign extended, only bits 3..0 matter for shifts
	assign imm4_sext = {{12{instr[3]}}, instr[3:0]};

	always_comb begin
		ctrl          = '0;
		ctrl.alu_op   = ALU_ADD;
		ctrl.wb_sel   = WB_ALU;
		ctrl.cond     = cond_t'(instr[11:9]);
		ctrl.imm      = imm4_sext;
		ctrl.byte_val = instr[7:0];
		rs = f_rs;
		rt = f_rt;
		rd = f_rd;
		case (opcode)
			OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR: begin
				// register-register, second operand from rt
				ctrl.reg_write  = 1'b1;
				ctrl.alu_op     = alu_op_t'(instr[14:12]);
				ctrl.flag_z_en  = 1'b1;
				ctrl.flag_vn_en = (opcode == OP_ADD) || (opcode == OP_SUB);
			end
			OP_SLL, OP_SRL, OP_SRA: begin
				// shift amount is imm4
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = alu_op_t'(instr[14:12]);
				ctrl.use_imm   = 1'b1;
				ctrl.flag_z_en = 1'b1;
			end
			OP_LW: begin
				// word offset, scaled to bytes
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = WB_MEM;
				ctrl.use_imm   = 1'b1;
				ctrl.imm       = {imm4_sext[14:0], 1'b0};
			end
			OP_SW: begin
				// store source sits in the rd field, read through the rt port
				ctrl.mem_write = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.imm       = {imm4_sext[14:0], 1'b0};
				rt = f_rd;
			end
			OP_LLB, OP_LHB: begin
				// old rd read on the rs port, add of zero passes it through the alu
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = WB_BYTE;
				ctrl.high_byte = (opcode == OP_LHB);
				ctrl.use_imm   = 1'b1;
				ctrl.imm       = '0;
				rs = f_rd;
			end
			OP_BRANCH: begin
				ctrl.branch = 1'b1;
				ctrl.imm    = {{6{imm9[8]}}, imm9, 1'b0};
			end
			OP_PCS: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = WB_PCS;
			end
			OP_HLT: begin
				ctrl.halt = 1'b1;
			end
			default: begin
				// OP_NOP keeps every default
			end
		endcase
	end

endmodule

// File: cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile import cpu_isa_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     we,
	input  reg_idx_t rs,
	input  reg_idx_t rt,
	input  reg_idx_t rd,
	input  word_t    wdata,
	output word_t    rs_data,
	output word_t    rt_data
);

	// r0 is an ordinary register here
	word_t regs [16];

	// write lands at the edge that ends the instruction
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rd] <= wdata;
		end
	end

	// combinational reads
	// no bypass needed, the write is never seen in the same cycle
	assign rs_data = regs[rs];
	assign rt_data = regs[rt];

endmodule

// File: cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute import cpu_isa_pkg::*; import cpu_ctrl_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  ctrl_t  ctrl,
	input  word_t  rs_data,
	input  word_t  rt_data,
	output word_t  alu_result,
	output flags_t flags
);

	word_t      operand_b;
	word_t      alu_out;
	word_t      mem_addr;
	logic       mem_op;
	logic       ovf;
	logic [3:0] shamt;

	// second operand
	assign operand_b = ctrl.use_imm ? ctrl.imm : rt_data;
	assign shamt     = operand_b[3:0];

	always_comb begin
		ovf = 1'b0;
		unique case (ctrl.alu_op)
			ALU_ADD: begin
				alu_out = rs_data + operand_b;
				// like signs in, other sign out
				ovf = (rs_data[15] == operand_b[15]) && (alu_out[15] != rs_data[15]);
			end
			ALU_SUB: begin
				alu_out = rs_data - operand_b;
				ovf = (rs_data[15] != operand_b[15]) && (alu_out[15] != rs_data[15]);
			end
			ALU_XOR: alu_out = rs_data ^ operand_b;
			ALU_AND: alu_out = rs_data & operand_b;
			ALU_OR:  alu_out = rs_data | operand_b;
			ALU_SLL: alu_out = rs_data << shamt;
			ALU_SRL: alu_out = rs_data >> shamt;
			ALU_SRA: alu_out = word_t'($signed(rs_data) >>> shamt);
		endcase
	end

	// lw / sw address, base forced to a word boundary
	assign mem_op   = ctrl.mem_write || (ctrl.wb_sel == WB_MEM);
	assign mem_addr = {rs_data[15:1], 1'b0} + ctrl.imm;

	assign alu_result = mem_op ? mem_addr : alu_out;

	// flag register
	// z_en covers z and n, vn_en covers v and n
	// so add/sub write all three and the rest write z and n
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags <= '0;
		end else begin
			if (ctrl.flag_z_en) begin
				flags.z <= (alu_out == '0);
			end
			if (ctrl.flag_z_en || ctrl.flag_vn_en) begin
				flags.n <= alu_out[15];
			end
			if (ctrl.flag_vn_en) begin
				flags.v <= ovf;
			end
		end
	end

endmodule

// File: cpu_mem_wb.sv
`timescale 1ns/1ps

module cpu_mem_wb import cpu_isa_pkg::*; import cpu_ctrl_pkg::*; (
	input  ctrl_t ctrl,
	input  word_t alu_result,
	input  word_t store_data,
	input  word_t pc,
	input  word_t dmem_rdata,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic  dmem_we,
	output word_t wb_data
);

	word_t byte_merged;

	// data memory port, address comes from execute
	assign dmem_addr  = alu_result;
	assign dmem_wdata = store_data;
	// one-cycle write strobe, memory takes it on the rising edge
	assign dmem_we    = ctrl.mem_write;

	// llb / lhb: alu_result carries the old rd
	assign byte_merged = ctrl.high_byte ? {ctrl.byte_val, alu_result[7:0]}
		: {alu_result[15:8], ctrl.byte_val};

	// write-back mux
	always_comb begin
		unique case (ctrl.wb_sel)
			WB_ALU:  wb_data = alu_result;
			WB_MEM:  wb_data = dmem_rdata;
			WB_BYTE: wb_data = byte_merged;
			// return address for pcs
			WB_PCS:  wb_data = pc + 16'd2;
		endcase
	end

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_isa_pkg::*; import cpu_ctrl_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input  logic  clk,
	input  logic  rst_n,
	output word_t imem_addr,
	input  word_t imem_data,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic  dmem_we,
	input  word_t dmem_rdata,
	output logic  hlt
);

	word_t    pc;
	ctrl_t    ctrl;
	flags_t   flags;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	word_t    rs_data;
	word_t    rt_data;
	word_t    alu_result;
	word_t    wb_data;
	logic     store_we;

	// fetch address straight from the pc
	assign imem_addr = pc;
	// stays high while the hlt word is refetched
	// and stays low while reset is held
	assign hlt = ctrl.halt && rst_n;
	// the word fetched during reset never reaches the store port
	assign dmem_we = store_we && rst_n;

	cpu_fetch #(
		.RESET_PC(RESET_PC)
	) fetch_inst (
		.clk  (clk),
		.rst_n(rst_n),
		.ctrl (ctrl),
		.flags(flags),
		.pc   (pc)
	);

	cpu_decode decode_inst (
		.instr(imem_data),
		.ctrl (ctrl),
		.rs   (rs),
		.rt   (rt),
		.rd   (rd)
	);

	cpu_regfile regfile_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.we     (ctrl.reg_write),
		.rs     (rs),
		.rt     (rt),
		.rd     (rd),
		.wdata  (wb_data),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	cpu_execute execute_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.rs_data   (rs_data),
		.rt_data   (rt_data),
		.alu_result(alu_result),
		.flags     (flags)
	);

	// rt_data is the store source for sw
	cpu_mem_wb mem_wb_inst (
		.ctrl      (ctrl),
		.alu_result(alu_result),
		.store_data(rt_data),
		.pc        (pc),
		.dmem_rdata(dmem_rdata),
		.dmem_addr (dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we   (store_we),
		.wb_data   (wb_data)
	);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// release just after an edge, like every other tb input
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

// File: cpu_tb_assert.sv
`timescale 1ns/1ps

module cpu_tb_assert import cpu_isa_pkg::*; (
	input logic  clk,
	input logic  rst_n,
	input logic  dmem_we,
	input logic  hlt,
	input word_t imem_addr
);

	// nothing may be stored or halted while reset is held
	property reset_quiet;
		@(posedge clk) !rst_n |-> (!dmem_we && !hlt);
	endproperty

	// once halted the core is frozen until reset
	property halt_holds;
		@(posedge clk) disable iff (!rst_n)
			hlt |=> (hlt && $stable(imem_addr) && !dmem_we);
	endproperty

	reset_quiet_a: assert property (reset_quiet)
		else $error("store or halt seen during reset");
	halt_holds_a: assert property (halt_holds)
		else $error("core moved or stored after halt");

endmodule

bind cpu_top cpu_tb_assert cpu_tb_assert_inst (
	.clk      (clk),
	.rst_n    (rst_n),
	.dmem_we  (dmem_we),
	.hlt      (hlt),
	.imem_addr(imem_addr)
);

// File: cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_isa_pkg::*; ();

	localparam word_t RESET_PC = 16'h0000;

	typedef struct packed {
		word_t next_pc;
		logic  we;
		word_t addr;
		word_t data;
		logic  halt;
	} step_t;

	logic  clk;
	logic  rst_n;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic  dmem_we;
	word_t dmem_rdata;
	logic  hlt;

	// memories seen by the dut, and the isa model state
	word_t prog [256];
	int    sect [256];
	word_t data_mem [256];
	word_t m_mem [256];
	word_t m_regs [16];
	logic  m_z, m_v, m_n;
	word_t m_pc;

	logic [31:0] lfsr;
	int    n_prog;
	int    cur_build;
	int    cur_sect;
	int    checks, errors, passed, failed;
	int    test_err [7];
	string test_name [7];
	int    halt_cycles;
	int    cycles, limit;
	logic  done;
	step_t s;
	word_t old_pc;
	word_t r;
	word_t setups [5];
	int    k;

	tb_clock_gen clk_gen_inst (
		.clk  (clk),
		.rst_n(rst_n)
	);

	cpu_top #(
		.RESET_PC(RESET_PC)
	) cpu_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.dmem_addr (dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we   (dmem_we),
		.dmem_rdata(dmem_rdata),
		.hlt       (hlt)
	);

	// 32-bit fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] st);
		return {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};
	endfunction

	// one lfsr step per bit taken
	function automatic word_t rand_bits(input int nbits);
		word_t v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic void emit(input word_t w);
		prog[n_prog] = w;
		sect[n_prog] = cur_build;
		n_prog++;
	endfunction

	// isa model, one instruction per call
	function automatic step_t ref_step(input word_t instr);
		step_t st;
		logic [3:0] op, a, b, c;
		word_t x, y, res, addr;
		int sum;
		logic take;
		st = '0;
		op = instr[15:12];
		a = instr[11:8];
		b = instr[7:4];
		c = instr[3:0];
		x = m_regs[b];
		y = m_regs[c];
		st.next_pc = m_pc + 16'd2;
		addr = {x[15:1], 1'b0} + {{11{c[3]}}, c, 1'b0};
		case (op)
			4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
				case (op)
					4'h0: begin
						res = x + y;
						sum = int'($signed(x)) + int'($signed(y));
						m_v = (sum > 32767) || (sum < -32768);
					end
					4'h1: begin
						res = x - y;
						sum = int'($signed(x)) - int'($signed(y));
						m_v = (sum > 32767) || (sum < -32768);
					end
					4'h2: res = x ^ y;
					4'h3: res = x & y;
					4'h4: res = x | y;
					4'h5: res = x << c;
					4'h6: res = x >> c;
					default: begin
						// logical shift, then the vacated top bits take the sign
						res = x >> c;
						if (x[15]) begin
							res = res | ~(16'hFFFF >> c);
						end
					end
				endcase
				m_z = (res == 16'h0000);
				m_n = res[15];
				m_regs[a] = res;
			end
			4'h8: m_regs[a] = m_mem[addr[8:1]];
			4'h9: begin
				st.we = 1'b1;
				st.addr = addr;
				st.data = m_regs[a];
				m_mem[addr[8:1]] = m_regs[a];
			end
			4'hA: m_regs[a][7:0] = instr[7:0];
			4'hB: m_regs[a][15:8] = instr[7:0];
			4'hC: begin
				case (instr[11:9])
					3'd0: take = !m_z;
					3'd1: take = m_z;
					3'd2: take = !m_z && !m_n;
					3'd3: take = m_n;
					3'd4: take = m_z || !m_n;
					3'd5: take = m_z || m_n;
					3'd6: take = m_v;
					default: take = 1'b1;
				endcase
				if (take) begin
					st.next_pc = m_pc + 16'd2 + {{6{instr[8]}}, instr[8:0], 1'b0};
				end
			end
			4'hE: m_regs[a] = m_pc + 16'd2;
			4'hF: begin
				st.next_pc = m_pc;
				st.halt = 1'b1;
			end
			default: begin
			end
		endcase
		m_pc = st.next_pc;
		return st;
	endfunction

	task automatic check(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_err[cur_sect]++;
			$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input int id);
		if (test_err[id] == 0) begin
			passed++;
			$display("test %0d %s: ok", id, test_name[id]);
		end else begin
			failed++;
			$display("test %0d %s: %0d errors", id, test_name[id], test_err[id]);
		end
	endtask

	// memory models, fetch first since the data address depends on it
	always @(posedge clk) begin
		#1 imem_data = prog[imem_addr[8:1]];
		#1 dmem_rdata = data_mem[dmem_addr[8:1]];
	end

	always @(posedge clk) begin
		if (rst_n && dmem_we) begin
			data_mem[dmem_addr[8:1]] <= dmem_wdata;
		end
	end

	// compare against the model at every edge
	always @(posedge clk) begin
		if (!rst_n) begin
			check("dmem_we", {15'b0, dmem_we}, 16'h0000);
			check("hlt", {15'b0, hlt}, 16'h0000);
		end else if (!done) begin
			old_pc = m_pc;
			if (sect[old_pc[8:1]] != cur_sect) begin
				report_test(cur_sect);
				cur_sect = sect[old_pc[8:1]];
			end
			s = ref_step(prog[old_pc[8:1]]);
			check("pc", imem_addr, old_pc);
			check("hlt", {15'b0, hlt}, {15'b0, s.halt});
			check("dmem_we", {15'b0, dmem_we}, {15'b0, s.we});
			if (s.we) begin
				check("dmem_addr", dmem_addr, s.addr);
				check("dmem_wdata", dmem_wdata, s.data);
			end
			if (s.halt) begin
				halt_cycles++;
				// a few held cycles prove the halt sticks
				if (halt_cycles == 8) begin
					report_test(cur_sect);
					done = 1'b1;
				end
			end
		end
	end

	initial begin
		// a hlt word ahead of the first edge exercises the reset mask on hlt
		imem_data = 16'hF000;
		dmem_rdata = '0;
		lfsr = 32'h7ceab00d;
		n_prog = 0;
		cur_sect = 1;
		checks = 0;
		errors = 0;
		passed = 0;
		failed = 0;
		halt_cycles = 0;
		done = 1'b0;
		m_pc = RESET_PC;
		{m_z, m_v, m_n} = 3'b000;
		test_name = '{"", "reset", "alu and flags", "byte loads and memory",
			"branches", "pcs", "hlt"};
		for (int i = 0; i < 7; i++) begin
			test_err[i] = 0;
		end
		for (int i = 0; i < 16; i++) begin
			m_regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			data_mem[i] = rand_bits(16);
			m_mem[i] = data_mem[i];
		end

		// random register contents, then random alu ops, then dump everything
		cur_build = 2;
		// a store at the reset pc so the fetch port shows it during reset
		emit({4'h9, 4'd0, 4'd0, 4'd0});
		for (int i = 0; i < 16; i++) begin
			r = rand_bits(16);
			emit({4'hA, i[3:0], r[7:0]});
			emit({4'hB, i[3:0], r[15:8]});
		end
		for (int i = 0; i < 32; i++) begin
			r = rand_bits(15);
			emit({1'b0, r[14:0]});
		end
		// r14 goes out through itself before it becomes the base
		emit({4'h9, 4'd14, 4'd14, 4'd0});
		emit({4'hA, 4'd14, 8'h40});
		emit({4'hB, 4'd14, 8'h00});
		for (int i = 0; i < 16; i++) begin
			k = i - 8;
			emit({4'h9, i[3:0], 4'd14, k[3:0]});
		end

		// constants, word moves, odd base and a memory round trip
		cur_build = 3;
		emit({4'hA, 4'd1, 8'h34});
		emit({4'hB, 4'd1, 8'h12});
		emit({4'hA, 4'd2, 8'h00});
		emit({4'hB, 4'd2, 8'h01});
		emit({4'h9, 4'd1, 4'd2, 4'd2});
		emit({4'h8, 4'd3, 4'd2, 4'd2});
		emit({4'h8, 4'd4, 4'd2, 4'hD});
		emit({4'h9, 4'd3, 4'd2, 4'd5});
		emit({4'h9, 4'd4, 4'd2, 4'd6});
		emit({4'hA, 4'd5, 8'h01});
		emit({4'hB, 4'd5, 8'h01});
		emit({4'h8, 4'd6, 4'd5, 4'd1});
		emit({4'h9, 4'd6, 4'd2, 4'd7});

		// every condition after five flag setups, branch skips one marker
		cur_build = 4;
		emit({4'hA, 4'd8, 8'h01});
		emit({4'hB, 4'd8, 8'h00});
		emit({4'hA, 4'd9, 8'h02});
		emit({4'hB, 4'd9, 8'h00});
		emit({4'hA, 4'd10, 8'hFF});
		emit({4'hB, 4'd10, 8'h7F});
		// zero, negative, positive, overflow, no overflow
		setups = '{16'h2C88, 16'h1C89, 16'h2C89, 16'h0CA8, 16'h0C88};
		for (int c = 0; c < 8; c++) begin
			for (int j = 0; j < 5; j++) begin
				k = c * 8 + j;
				emit(setups[j]);
				emit({4'hC, c[2:0], 9'd1});
				emit({4'hA, 4'd13, k[7:0]});
			end
		end
		emit({4'h9, 4'd13, 4'd2, 4'd3});

		cur_build = 5;
		emit({4'hE, 4'd1, 8'h00});
		emit({4'h9, 4'd1, 4'd2, 4'd4});

		cur_build = 6;
		limit = n_prog * 2 + 100;
		while (n_prog < 256) begin
			emit(16'hF000);
		end

		cycles = 0;
		@(posedge rst_n);
		// pc sits at the reset value when reset lets go
		check("pc", imem_addr, RESET_PC);
		while (!done && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("timeout: cpu did not settle in halt within %0d cycles", limit);
		end
		$display("tests passed %0d failed %0d, checks %0d, errors %0d",
			passed, failed, checks, errors);
		if (done && errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: verilog.f
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
cpu_fetch.sv
cpu_decode.sv
cpu_regfile.sv
cpu_execute.sv
cpu_mem_wb.sv
cpu_top.sv
tb_clock_gen.sv
cpu_tb_assert.sv
cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# pass only when the testbench printed the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
